// File: source/mmu_pkg.sv
// sv39 mmu widths, vector typedefs, privilege levels, exception causes and tlb size
package mmu_pkg;

    // ------------------------------
    // address and id widths
    // ------------------------------
    // virtual address, sv39
    localparam int unsigned VLEN  = 39;
    // physical address
    localparam int unsigned PLEN  = 56;
    // physical page number, PLEN minus the 12 bit page offset
    localparam int unsigned PPNW  = 44;
    // virtual page number, three 9 bit levels
    localparam int unsigned VPNW  = 27;
    localparam int unsigned ASIDW = 4;

    // default entry count of each tlb
    localparam int unsigned TLB_ENTRIES = 4;

    // ------------------------------
    // vector types
    // ------------------------------
    typedef logic [VLEN-1:0]  vaddr_t;
    typedef logic [PLEN-1:0]  paddr_t;
    typedef logic [PPNW-1:0]  ppn_t;
    // [26:18] level 2, [17:9] level 1, [8:0] level 0
    typedef logic [VPNW-1:0]  vpn_t;
    typedef logic [ASIDW-1:0] asid_t;

    // privilege level, encoding as in mstatus.mpp
    typedef logic [1:0] priv_lvl_t;
    localparam priv_lvl_t PRIV_U = 2'd0;
    localparam priv_lvl_t PRIV_S = 2'd1;
    localparam priv_lvl_t PRIV_M = 2'd3;

    // ------------------------------
    // exception causes (mcause codes)
    // ------------------------------
    typedef logic [3:0] exc_cause_t;
    localparam exc_cause_t CAUSE_INSTR_ACCESS = 4'd1;
    localparam exc_cause_t CAUSE_INSTR_PAGE   = 4'd12;
    localparam exc_cause_t CAUSE_LOAD_PAGE    = 4'd13;
    localparam exc_cause_t CAUSE_STORE_PAGE   = 4'd15;

endpackage

// File: source/tlb_if.sv
// tlb lookup interface and tlb refill interface
`timescale 1ns/1ps

// one lookup from a translator, answered combinationally by the tlb
interface tlb_lookup_if import mmu_pkg::*; ();
    // request side
    logic   access;
    vaddr_t vaddr;
    asid_t  asid;
    // answer side, same cycle
    logic   hit;
    ppn_t   ppn;
    logic   is_2m;
    logic   is_1g;
    // pte flags of the hitting entry
    logic   u;
    logic   w;
    logic   d;

    modport requester (output access, vaddr, asid,
                       input  hit, ppn, is_2m, is_1g, u, w, d);
    modport responder (input  access, vaddr, asid,
                       output hit, ppn, is_2m, is_1g, u, w, d);
endinterface

// refill of one tlb entry, valid is a single cycle strobe
interface tlb_update_if import mmu_pkg::*; ();
    logic  valid;
    vpn_t  vpn;
    asid_t asid;
    ppn_t  ppn;
    logic  is_2m;
    logic  is_1g;
    logic  u;
    logic  w;
    logic  d;

    modport source (output valid, vpn, asid, ppn, is_2m, is_1g, u, w, d);
    modport sink   (input  valid, vpn, asid, ppn, is_2m, is_1g, u, w, d);
endinterface

// File: source/tlb.sv
// fully associative tlb with superpage match, asid, flush and round-robin refill
`timescale 1ns/1ps

module tlb import mmu_pkg::*; #(
    parameter int unsigned NUM_ENTRIES = TLB_ENTRIES
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            flush_i,
    tlb_lookup_if.responder lu,
    tlb_update_if.sink      upd
);

    localparam int unsigned IDX_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

    // entry array
    logic [NUM_ENTRIES-1:0] valid_q;
    vpn_t                   vpn_q  [NUM_ENTRIES];
    asid_t                  asid_q [NUM_ENTRIES];
    ppn_t                   ppn_q  [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0] is_2m_q;
    logic [NUM_ENTRIES-1:0] is_1g_q;
    logic [NUM_ENTRIES-1:0] u_q;
    logic [NUM_ENTRIES-1:0] w_q;
    logic [NUM_ENTRIES-1:0] d_q;

    // next entry to be overwritten
    logic [IDX_W-1:0]       rr_q;
    logic [NUM_ENTRIES-1:0] match;

    // ------------------------------
    // parallel compare
    // ------------------------------
    always_comb begin : match_entries
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            // level 2 always compared, lower levels only below the page size
            match[i] = valid_q[i] && (asid_q[i] == lu.asid)
                    && (vpn_q[i][26:18] == lu.vaddr[38:30])
                    && (is_1g_q[i]
                        || ((vpn_q[i][17:9] == lu.vaddr[29:21])
                            && (is_2m_q[i] || (vpn_q[i][8:0] == lu.vaddr[20:12]))));
        end
    end

    always_comb begin : select_hit
        lu.ppn   = '0;
        lu.is_2m = 1'b0;
        lu.is_1g = 1'b0;
        lu.u     = 1'b0;
        lu.w     = 1'b0;
        lu.d     = 1'b0;
        // walk downwards so the lowest matching index wins
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                lu.ppn   = ppn_q[i];
                lu.is_2m = is_2m_q[i];
                lu.is_1g = is_1g_q[i];
                lu.u     = u_q[i];
                lu.w     = w_q[i];
                lu.d     = d_q[i];
            end
        end
        lu.hit = lu.access && (|match);
    end

    // ------------------------------
    // refill and flush
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            rr_q    <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
            rr_q    <= '0;
        end else if (upd.valid) begin
            valid_q[rr_q] <= 1'b1;
            // advance and wrap, even when the page was already present
            rr_q <= (rr_q == IDX_W'(NUM_ENTRIES - 1)) ? '0 : rr_q + 1'b1;
        end
    end

    // entry contents, qualified by valid_q
    always_ff @(posedge clk_i) begin
        if (upd.valid) begin
            vpn_q[rr_q]   <= upd.vpn;
            asid_q[rr_q]  <= upd.asid;
            ppn_q[rr_q]   <= upd.ppn;
            is_2m_q[rr_q] <= upd.is_2m;
            is_1g_q[rr_q] <= upd.is_1g;
            u_q[rr_q]     <= upd.u;
            w_q[rr_q]     <= upd.w;
            d_q[rr_q]     <= upd.d;
        end
    end

endmodule

// File: source/fetch_xlate.sv
// same-cycle instruction fetch translation with access and page fault checks
`timescale 1ns/1ps

module fetch_xlate import mmu_pkg::*; (
    input  logic             enable_translation_i,
    input  priv_lvl_t        priv_lvl_i,
    input  logic             fetch_req_i,
    input  vaddr_t           fetch_vaddr_i,
    input  asid_t            asid_i,
    tlb_lookup_if.requester  itlb,
    output logic             fetch_valid_o,
    output paddr_t           fetch_paddr_o,
    output logic             fetch_exc_valid_o,
    output exc_cause_t       fetch_exc_cause_o,
    output vaddr_t           fetch_exc_tval_o
);

    logic iaccess_err;
    logic non_canonical;

    // every fetch request goes straight to the itlb
    assign itlb.access = fetch_req_i;
    assign itlb.vaddr  = fetch_vaddr_i;
    assign itlb.asid   = asid_i;

    // U on a supervisor page, or S on a user page
    assign iaccess_err = ((priv_lvl_i == PRIV_U) && !itlb.u)
                      || ((priv_lvl_i == PRIV_S) && itlb.u);

    // the two sign bits at the top of the 39 bit address must agree
    assign non_canonical = !((&fetch_vaddr_i[VLEN-1:VLEN-2])
                          || !(|fetch_vaddr_i[VLEN-1:VLEN-2]));

    assign fetch_exc_tval_o = fetch_vaddr_i;

    always_comb begin : fetch_path
        // translation off: pass through, zero-extended
        fetch_valid_o     = fetch_req_i;
        fetch_paddr_o     = {{(PLEN-VLEN){1'b0}}, fetch_vaddr_i};
        fetch_exc_valid_o = 1'b0;
        fetch_exc_cause_o = '0;

        if (enable_translation_i) begin
            // 4k page, then splice the offset bits of superpages
            fetch_paddr_o = {itlb.ppn, fetch_vaddr_i[11:0]};
            if (itlb.is_2m) begin
                fetch_paddr_o[20:12] = fetch_vaddr_i[20:12];
            end
            if (itlb.is_1g) begin
                fetch_paddr_o[29:12] = fetch_vaddr_i[29:12];
            end
            // miss holds valid low until a refill
            fetch_valid_o = itlb.hit;

            // access fault does not depend on the tlb answer
            if (fetch_req_i && non_canonical) begin
                fetch_exc_valid_o = 1'b1;
                fetch_exc_cause_o = CAUSE_INSTR_ACCESS;
            end
            // page fault takes priority
            if (itlb.hit && iaccess_err) begin
                fetch_exc_valid_o = 1'b1;
                fetch_exc_cause_o = CAUSE_INSTR_PAGE;
            end
        end
    end

endmodule

// File: source/lsu_xlate.sv
// load/store translation, registered for one cycle, with page fault checks
`timescale 1ns/1ps

module lsu_xlate import mmu_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             en_ld_st_translation_i,
    input  priv_lvl_t        ld_st_priv_lvl_i,
    input  logic             sum_i,
    input  logic             lsu_req_i,
    input  vaddr_t           lsu_vaddr_i,
    input  logic             lsu_is_store_i,
    input  asid_t            asid_i,
    tlb_lookup_if.requester  dtlb,
    output logic             lsu_dtlb_hit_o,
    output logic             lsu_valid_o,
    output paddr_t           lsu_paddr_o,
    output logic             lsu_exc_valid_o,
    output exc_cause_t       lsu_exc_cause_o,
    output vaddr_t           lsu_exc_tval_o
);

    // cycle 1 copy of the request and the dtlb answer
    logic   req_q;
    logic   hit_q;
    vaddr_t vaddr_q;
    logic   is_store_q;
    ppn_t   ppn_q;
    logic   is_2m_q;
    logic   is_1g_q;
    logic   u_q;
    logic   w_q;
    logic   d_q;

    logic   daccess_err;

    // ------------------------------
    // cycle 0, lookup
    // ------------------------------
    assign dtlb.access = lsu_req_i;
    assign dtlb.vaddr  = lsu_vaddr_i;
    assign dtlb.asid   = asid_i;

    // always a hit when nothing is translated
    assign lsu_dtlb_hit_o = en_ld_st_translation_i ? dtlb.hit : 1'b1;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q <= 1'b0;
            hit_q <= 1'b0;
        end else begin
            req_q <= lsu_req_i;
            hit_q <= dtlb.hit;
        end
    end

    always_ff @(posedge clk_i) begin
        vaddr_q    <= lsu_vaddr_i;
        is_store_q <= lsu_is_store_i;
        ppn_q      <= dtlb.ppn;
        is_2m_q    <= dtlb.is_2m;
        is_1g_q    <= dtlb.is_1g;
        u_q        <= dtlb.u;
        w_q        <= dtlb.w;
        d_q        <= dtlb.d;
    end

    // ------------------------------
    // cycle 1, response
    // ------------------------------
    // S without SUM on a user page, or U on a supervisor page
    assign daccess_err = ((ld_st_priv_lvl_i == PRIV_S) && !sum_i && u_q)
                      || ((ld_st_priv_lvl_i == PRIV_U) && !u_q);

    assign lsu_exc_tval_o = vaddr_q;

    always_comb begin : lsu_response
        lsu_valid_o     = req_q;
        lsu_paddr_o     = {{(PLEN-VLEN){1'b0}}, vaddr_q};
        lsu_exc_valid_o = 1'b0;
        lsu_exc_cause_o = '0;

        if (en_ld_st_translation_i) begin
            lsu_paddr_o = {ppn_q, vaddr_q[11:0]};
            if (is_2m_q) begin
                lsu_paddr_o[20:12] = vaddr_q[20:12];
            end
            if (is_1g_q) begin
                lsu_paddr_o[29:12] = vaddr_q[29:12];
            end
            lsu_valid_o = req_q && hit_q;

            if (req_q && hit_q) begin
                // stores also need the write and dirty bits
                if (is_store_q) begin
                    if (daccess_err || !w_q || !d_q) begin
                        lsu_exc_valid_o = 1'b1;
                        lsu_exc_cause_o = CAUSE_STORE_PAGE;
                    end
                end else if (daccess_err) begin
                    lsu_exc_valid_o = 1'b1;
                    lsu_exc_cause_o = CAUSE_LOAD_PAGE;
                end
            end
        end
    end

endmodule

// File: source/mmu.sv
// sv39 mmu top with instruction and data tlbs, both translators and refill steering
`timescale 1ns/1ps

module mmu import mmu_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       flush_i,
    input  logic       enable_translation_i,
    input  logic       en_ld_st_translation_i,
    input  priv_lvl_t  priv_lvl_i,
    input  priv_lvl_t  ld_st_priv_lvl_i,
    input  logic       sum_i,
    input  asid_t      asid_i,
    // instruction fetch
    input  logic       fetch_req_i,
    input  vaddr_t     fetch_vaddr_i,
    output logic       fetch_valid_o,
    output paddr_t     fetch_paddr_o,
    output logic       fetch_exc_valid_o,
    output exc_cause_t fetch_exc_cause_o,
    output vaddr_t     fetch_exc_tval_o,
    // load/store
    input  logic       lsu_req_i,
    input  vaddr_t     lsu_vaddr_i,
    input  logic       lsu_is_store_i,
    output logic       lsu_dtlb_hit_o,
    output logic       lsu_valid_o,
    output paddr_t     lsu_paddr_o,
    output logic       lsu_exc_valid_o,
    output exc_cause_t lsu_exc_cause_o,
    output vaddr_t     lsu_exc_tval_o,
    // tlb refill
    input  logic       upd_valid_i,
    input  logic       upd_is_instr_i,
    input  vpn_t       upd_vpn_i,
    input  asid_t      upd_asid_i,
    input  ppn_t       upd_ppn_i,
    input  logic       upd_is_2m_i,
    input  logic       upd_is_1g_i,
    input  logic       upd_u_i,
    input  logic       upd_w_i,
    input  logic       upd_d_i
);

    tlb_lookup_if itlb_lu ();
    tlb_lookup_if dtlb_lu ();
    tlb_update_if itlb_upd ();
    tlb_update_if dtlb_upd ();

    // ------------------------------
    // refill steering
    // ------------------------------
    // only the strobe is split, the entry fields go to both tlbs
    assign itlb_upd.valid = upd_valid_i && upd_is_instr_i;
    assign dtlb_upd.valid = upd_valid_i && !upd_is_instr_i;

    assign itlb_upd.vpn   = upd_vpn_i;
    assign itlb_upd.asid  = upd_asid_i;
    assign itlb_upd.ppn   = upd_ppn_i;
    assign itlb_upd.is_2m = upd_is_2m_i;
    assign itlb_upd.is_1g = upd_is_1g_i;
    assign itlb_upd.u     = upd_u_i;
    assign itlb_upd.w     = upd_w_i;
    assign itlb_upd.d     = upd_d_i;

    assign dtlb_upd.vpn   = upd_vpn_i;
    assign dtlb_upd.asid  = upd_asid_i;
    assign dtlb_upd.ppn   = upd_ppn_i;
    assign dtlb_upd.is_2m = upd_is_2m_i;
    assign dtlb_upd.is_1g = upd_is_1g_i;
    assign dtlb_upd.u     = upd_u_i;
    assign dtlb_upd.w     = upd_w_i;
    assign dtlb_upd.d     = upd_d_i;

    // ------------------------------
    // tlbs
    // ------------------------------
    tlb #(.NUM_ENTRIES(TLB_ENTRIES)) u_itlb (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .lu      (itlb_lu.responder),
        .upd     (itlb_upd.sink)
    );

    tlb #(.NUM_ENTRIES(TLB_ENTRIES)) u_dtlb (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .lu      (dtlb_lu.responder),
        .upd     (dtlb_upd.sink)
    );

    // ------------------------------
    // translators
    // ------------------------------
    fetch_xlate u_fetch_xlate (
        .enable_translation_i (enable_translation_i),
        .priv_lvl_i           (priv_lvl_i),
        .fetch_req_i          (fetch_req_i),
        .fetch_vaddr_i        (fetch_vaddr_i),
        .asid_i               (asid_i),
        .itlb                 (itlb_lu.requester),
        .fetch_valid_o        (fetch_valid_o),
        .fetch_paddr_o        (fetch_paddr_o),
        .fetch_exc_valid_o    (fetch_exc_valid_o),
        .fetch_exc_cause_o    (fetch_exc_cause_o),
        .fetch_exc_tval_o     (fetch_exc_tval_o)
    );

    lsu_xlate u_lsu_xlate (
        .clk_i                  (clk_i),
        .rst_ni                 (rst_ni),
        .en_ld_st_translation_i (en_ld_st_translation_i),
        .ld_st_priv_lvl_i       (ld_st_priv_lvl_i),
        .sum_i                  (sum_i),
        .lsu_req_i              (lsu_req_i),
        .lsu_vaddr_i            (lsu_vaddr_i),
        .lsu_is_store_i         (lsu_is_store_i),
        .asid_i                 (asid_i),
        .dtlb                   (dtlb_lu.requester),
        .lsu_dtlb_hit_o         (lsu_dtlb_hit_o),
        .lsu_valid_o            (lsu_valid_o),
        .lsu_paddr_o            (lsu_paddr_o),
        .lsu_exc_valid_o        (lsu_exc_valid_o),
        .lsu_exc_cause_o        (lsu_exc_cause_o),
        .lsu_exc_tval_o         (lsu_exc_tval_o)
    );

endmodule

// File: tests/mmu_assert.sv
// concurrent assertions on the mmu reset state and response rules
`timescale 1ns/1ps

module mmu_assert (
    input logic clk_i,
    input logic rst_ni,
    input logic fetch_req_i,
    input logic fetch_valid_i,
    input logic lsu_req_i,
    input logic lsu_valid_i,
    input logic lsu_exc_valid_i
);

    // failed assertions seen so far
    int fail_count = 0;

    // nothing valid while reset is held
    property p_quiet_in_reset;
        @(posedge clk_i) !rst_ni |-> (!fetch_valid_i && !lsu_valid_i && !lsu_exc_valid_i);
    endproperty

    // lsu answer only follows a request from the cycle before
    property p_lsu_valid_after_req;
        @(posedge clk_i) disable iff (!rst_ni) $rose(lsu_valid_i) |-> $past(lsu_req_i);
    endproperty

    // the fetch path is combinational so valid needs a live request
    property p_fetch_valid_with_req;
        @(posedge clk_i) disable iff (!rst_ni) fetch_valid_i |-> fetch_req_i;
    endproperty

    a_quiet_in_reset: assert property (p_quiet_in_reset)
        else begin
            fail_count++;
            $error("mmu valid output high during reset");
        end
    a_lsu_valid_after_req: assert property (p_lsu_valid_after_req)
        else begin
            fail_count++;
            $error("lsu_valid_o rose without a request one cycle earlier");
        end
    a_fetch_valid_with_req: assert property (p_fetch_valid_with_req)
        else begin
            fail_count++;
            $error("fetch_valid_o high without fetch_req_i");
        end

endmodule

// File: tests/tb_mmu.sv
// mmu testbench with clock, reset, directed tests, typed compares and closing report
`timescale 1ns/1ps

module tb_mmu import mmu_pkg::*; ();

    localparam int    CLK_PERIOD   = 10;
    localparam int    RESET_CYCLES = 5;
    // falling edges to wait for a load/store answer
    localparam int    LSU_TIMEOUT  = 4;
    localparam asid_t ASID         = 4'd3;

    // ------------------------------
    // test pages as level2 level1 level0 offset
    // ------------------------------
    localparam vaddr_t VA_PT    = 39'h40_1234_5678;
    localparam vaddr_t VA_4K    = {9'h001, 9'h002, 9'h003, 12'h345};
    localparam vaddr_t VA_2M    = {9'h004, 9'h005, 9'h1a7, 12'h678};
    localparam vaddr_t VA_1G    = {9'h006, 9'h0f1, 9'h1b2, 12'h9cd};
    localparam vaddr_t VA_USR   = {9'h007, 9'h011, 9'h022, 12'h0ab};
    localparam vaddr_t VA_MISS  = {9'h055, 9'h033, 9'h044, 12'h100};
    localparam vaddr_t VA_E     = {9'h008, 9'h009, 9'h00a, 12'hbee};
    // bit 37 set, bit 38 clear
    localparam vaddr_t VA_NONCA = 39'h20_0000_0000;
    localparam ppn_t   PPN_4K   = 44'h000_0abc_d123;
    localparam ppn_t   PPN_2M   = 44'h123_4567_89ab;
    localparam ppn_t   PPN_1G   = 44'h0fe_dcba_9876;
    localparam ppn_t   PPN_USR  = 44'h000_0000_5555;
    localparam ppn_t   PPN_E    = 44'h00e_eeee_0001;

    logic       clk_i, rst_ni, flush_i;
    logic       enable_translation_i, en_ld_st_translation_i, sum_i;
    priv_lvl_t  priv_lvl_i, ld_st_priv_lvl_i;
    asid_t      asid_i;
    logic       fetch_req_i, fetch_valid_o, fetch_exc_valid_o;
    vaddr_t     fetch_vaddr_i, fetch_exc_tval_o;
    paddr_t     fetch_paddr_o;
    exc_cause_t fetch_exc_cause_o;
    logic       lsu_req_i, lsu_is_store_i, lsu_dtlb_hit_o, lsu_valid_o, lsu_exc_valid_o;
    vaddr_t     lsu_vaddr_i, lsu_exc_tval_o;
    paddr_t     lsu_paddr_o;
    exc_cause_t lsu_exc_cause_o;
    logic       upd_valid_i, upd_is_instr_i, upd_is_2m_i, upd_is_1g_i;
    logic       upd_u_i, upd_w_i, upd_d_i;
    vpn_t       upd_vpn_i;
    asid_t      upd_asid_i;
    ppn_t       upd_ppn_i;

    int errors = 0;
    int checks = 0;

    mmu u_mmu (.*);

    bind mmu mmu_assert u_mmu_assert (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .fetch_req_i     (fetch_req_i),
        .fetch_valid_i   (fetch_valid_o),
        .lsu_req_i       (lsu_req_i),
        .lsu_valid_i     (lsu_valid_o),
        .lsu_exc_valid_i (lsu_exc_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ------------------------------
    // compares and expected values
    // ------------------------------
    task automatic report_error(input string what);
        errors++;
        $display("[ERROR] %0t %s", $time, what);
    endtask

    task automatic check_paddr(input string name, input paddr_t got, input paddr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_cause(input string name, input exc_cause_t got, input exc_cause_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_tval(input string name, input vaddr_t got, input vaddr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // the page offset widens with the page size
    function automatic paddr_t expect_paddr(input ppn_t ppn, input vaddr_t va,
                                            input logic is_2m, input logic is_1g);
        if (is_1g) begin
            return {ppn[43:18], va[29:0]};
        end else if (is_2m) begin
            return {ppn[43:9], va[20:0]};
        end
        return {ppn, va[11:0]};
    endfunction

    // ------------------------------
    // drivers start and end on a falling edge
    // ------------------------------
    task automatic refill(input logic is_instr, input vaddr_t va, input ppn_t ppn,
                          input logic is_2m, input logic is_1g,
                          input logic u, input logic w, input logic d);
        upd_valid_i    = 1'b1;
        upd_is_instr_i = is_instr;
        // superpage entries hold only the page base
        upd_vpn_i      = va[38:12];
        if (is_2m) begin
            upd_vpn_i[8:0] = '0;
        end
        if (is_1g) begin
            upd_vpn_i[17:0] = '0;
        end
        upd_asid_i     = ASID;
        upd_ppn_i      = ppn;
        upd_is_2m_i    = is_2m;
        upd_is_1g_i    = is_1g;
        upd_u_i        = u;
        upd_w_i        = w;
        upd_d_i        = d;
        @(negedge clk_i);
        upd_valid_i = 1'b0;
    endtask

    task automatic flush_tlbs();
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
    endtask

    task automatic fetch_check(input vaddr_t va, input logic exp_valid, input paddr_t exp_paddr,
                               input logic exp_exc, input exc_cause_t exp_cause);
        fetch_req_i   = 1'b1;
        fetch_vaddr_i = va;
        // let the same cycle answer settle
        #1;
        check_bit("fetch_valid_o", fetch_valid_o, exp_valid);
        if (exp_valid) begin
            check_paddr("fetch_paddr_o", fetch_paddr_o, exp_paddr);
        end
        check_bit("fetch_exc_valid_o", fetch_exc_valid_o, exp_exc);
        if (exp_exc) begin
            check_cause("fetch_exc_cause_o", fetch_exc_cause_o, exp_cause);
            check_tval("fetch_exc_tval_o", fetch_exc_tval_o, va);
        end
        @(negedge clk_i);
        fetch_req_i = 1'b0;
    endtask

    task automatic lsu_check(input vaddr_t va, input logic is_store, input logic exp_hit,
                             input logic exp_valid, input paddr_t exp_paddr,
                             input logic exp_exc, input exc_cause_t exp_cause);
        logic seen;
        int   lat;
        seen           = 1'b0;
        lat            = 0;
        lsu_req_i      = 1'b1;
        lsu_vaddr_i    = va;
        lsu_is_store_i = is_store;
        #1;
        check_bit("lsu_dtlb_hit_o", lsu_dtlb_hit_o, exp_hit);
        // the answer is due one edge later and a miss never answers
        while (!seen && lat < LSU_TIMEOUT) begin
            @(negedge clk_i);
            lat++;
            if (lsu_valid_o && exp_valid) begin
                check_paddr("lsu_paddr_o", lsu_paddr_o, exp_paddr);
                check_bit("lsu_exc_valid_o", lsu_exc_valid_o, exp_exc);
                if (exp_exc) begin
                    check_cause("lsu_exc_cause_o", lsu_exc_cause_o, exp_cause);
                    check_tval("lsu_exc_tval_o", lsu_exc_tval_o, va);
                end
            end
            seen      = lsu_valid_o;
            lsu_req_i = 1'b0;
        end
        if (exp_valid && !seen) begin
            report_error($sformatf("no load/store answer within %0d cycles for %h",
                                   LSU_TIMEOUT, va));
        end else if (!exp_valid) begin
            check_bit("lsu_valid_o", seen, 1'b0);
        end else if (lat != 1) begin
            report_error($sformatf("load/store answer took %0d cycles instead of one", lat));
        end
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic test_pass_through();
        enable_translation_i   = 1'b0;
        en_ld_st_translation_i = 1'b0;
        // with the top address bit set the upper physical bits must stay zero
        fetch_check(VA_PT, 1'b1, paddr_t'(VA_PT), 1'b0, '0);
        lsu_check(VA_PT, 1'b0, 1'b1, 1'b1, paddr_t'(VA_PT), 1'b0, '0);
    endtask

    task automatic test_page_sizes();
        enable_translation_i   = 1'b1;
        en_ld_st_translation_i = 1'b1;
        for (int t = 1; t >= 0; t--) begin
            refill(t[0], VA_4K, PPN_4K, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
            refill(t[0], VA_2M, PPN_2M, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1);
            refill(t[0], VA_1G, PPN_1G, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1);
        end
        fetch_check(VA_4K, 1'b1, expect_paddr(PPN_4K, VA_4K, 1'b0, 1'b0), 1'b0, '0);
        fetch_check(VA_2M, 1'b1, expect_paddr(PPN_2M, VA_2M, 1'b1, 1'b0), 1'b0, '0);
        fetch_check(VA_1G, 1'b1, expect_paddr(PPN_1G, VA_1G, 1'b0, 1'b1), 1'b0, '0);
        lsu_check(VA_4K, 1'b0, 1'b1, 1'b1, expect_paddr(PPN_4K, VA_4K, 1'b0, 1'b0), 1'b0, '0);
        lsu_check(VA_2M, 1'b0, 1'b1, 1'b1, expect_paddr(PPN_2M, VA_2M, 1'b1, 1'b0), 1'b0, '0);
        lsu_check(VA_1G, 1'b0, 1'b1, 1'b1, expect_paddr(PPN_1G, VA_1G, 1'b0, 1'b1), 1'b0, '0);
    endtask

    task automatic test_fetch_faults();
        refill(1'b1, VA_USR, PPN_USR, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1);
        // user page from S mode
        fetch_check(VA_USR, 1'b1, expect_paddr(PPN_USR, VA_USR, 1'b0, 1'b0),
                    1'b1, CAUSE_INSTR_PAGE);
        priv_lvl_i = PRIV_U;
        fetch_check(VA_4K, 1'b1, expect_paddr(PPN_4K, VA_4K, 1'b0, 1'b0),
                    1'b1, CAUSE_INSTR_PAGE);
        fetch_check(VA_USR, 1'b1, expect_paddr(PPN_USR, VA_USR, 1'b0, 1'b0), 1'b0, '0);
        priv_lvl_i = PRIV_S;
        fetch_check(VA_NONCA, 1'b0, '0, 1'b1, CAUSE_INSTR_ACCESS);
        // miss stays invalid until a refill brings the page in
        fetch_check(VA_MISS, 1'b0, '0, 1'b0, '0);
        refill(1'b1, VA_MISS, PPN_E, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
        fetch_check(VA_MISS, 1'b1, expect_paddr(PPN_E, VA_MISS, 1'b0, 1'b0), 1'b0, '0);
    endtask

    task automatic test_lsu_faults();
        flush_tlbs();
        refill(1'b0, VA_4K, PPN_4K, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
        // 2m page without w, 1g page without d, then a user page
        refill(1'b0, VA_2M, PPN_2M, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
        refill(1'b0, VA_1G, PPN_1G, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
        refill(1'b0, VA_USR, PPN_USR, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1);
        lsu_check(VA_4K, 1'b1, 1'b1, 1'b1, expect_paddr(PPN_4K, VA_4K, 1'b0, 1'b0), 1'b0, '0);
        lsu_check(VA_2M, 1'b1, 1'b1, 1'b1, expect_paddr(PPN_2M, VA_2M, 1'b1, 1'b0),
                  1'b1, CAUSE_STORE_PAGE);
        lsu_check(VA_1G, 1'b1, 1'b1, 1'b1, expect_paddr(PPN_1G, VA_1G, 1'b0, 1'b1),
                  1'b1, CAUSE_STORE_PAGE);
        lsu_check(VA_USR, 1'b0, 1'b1, 1'b1, expect_paddr(PPN_USR, VA_USR, 1'b0, 1'b0),
                  1'b1, CAUSE_LOAD_PAGE);
        sum_i = 1'b1;
        lsu_check(VA_USR, 1'b0, 1'b1, 1'b1, expect_paddr(PPN_USR, VA_USR, 1'b0, 1'b0),
                  1'b0, '0);
        sum_i = 1'b0;
    endtask

    task automatic test_miss_rules();
        asid_i = 4'd5;
        lsu_check(VA_4K, 1'b0, 1'b0, 1'b0, '0, 1'b0, '0);
        asid_i = ASID;
        // the dtlb is full so the fifth refill lands on entry 0 which holds VA_4K
        refill(1'b0, VA_E, PPN_E, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
        lsu_check(VA_4K, 1'b0, 1'b0, 1'b0, '0, 1'b0, '0);
        lsu_check(VA_E, 1'b0, 1'b1, 1'b1, expect_paddr(PPN_E, VA_E, 1'b0, 1'b0), 1'b0, '0);
        refill(1'b1, VA_E, PPN_E, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
        fetch_check(VA_E, 1'b1, expect_paddr(PPN_E, VA_E, 1'b0, 1'b0), 1'b0, '0);
        flush_tlbs();
        lsu_check(VA_E, 1'b0, 1'b0, 1'b0, '0, 1'b0, '0);
        fetch_check(VA_E, 1'b0, '0, 1'b0, '0);
    endtask

    initial begin
        rst_ni = 1'b0;
        flush_i = 1'b0;
        enable_translation_i = 1'b0;
        en_ld_st_translation_i = 1'b0;
        priv_lvl_i = PRIV_S;
        ld_st_priv_lvl_i = PRIV_S;
        sum_i = 1'b0;
        asid_i = ASID;
        fetch_req_i = 1'b0;
        fetch_vaddr_i = '0;
        lsu_req_i = 1'b0;
        lsu_vaddr_i = '0;
        lsu_is_store_i = 1'b0;
        upd_valid_i = 1'b0;
        upd_is_instr_i = 1'b0;
        upd_vpn_i = '0;
        upd_asid_i = '0;
        upd_ppn_i = '0;
        {upd_is_2m_i, upd_is_1g_i, upd_u_i, upd_w_i, upd_d_i} = '0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_ni = 1'b1;
        @(negedge clk_i);
        test_pass_through();
        test_page_sizes();
        test_fetch_faults();
        test_lsu_faults();
        test_miss_rules();
        errors += u_mmu.u_mmu_assert.fail_count;
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
source/mmu_pkg.sv
source/tlb_if.sv
source/tlb.sv
source/fetch_xlate.sv
source/lsu_xlate.sv
source/mmu.sv
tests/mmu_assert.sv
tests/tb_mmu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mmu
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
